// ==== src/mem_pkg.sv ====
/*
 * Shared definitions for the SDRAM memory subsystem
 * Address and data widths, the controller request, the slot request
 * and the state encodings of the arbiter and the client slots.
 */
package mem_pkg;

    // Slot count for the request and grant vectors
    localparam int NSLOTS = 3;

    // 16-bit word addressing of the whole SDRAM
    typedef logic [21:0] sdram_addr_t;
    typedef logic [15:0] sdram_word_t;

    // Active low per byte, bit 1 is the upper byte
    typedef logic [1:0] byte_mask_t;

    // Complete access as seen by the SDRAM controller
    typedef struct packed {
        sdram_addr_t addr;
        logic        rnw;
        byte_mask_t  wrmask;
        sdram_word_t wdata;
    } sdram_req_t;

    // Slot read request, region offset already applied
    typedef struct packed {
        logic        req;
        sdram_addr_t addr;
    } slot_req_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_DATA
    } arb_state_e;

    typedef enum logic {
        READY,
        FETCH
    } fetch_state_e;

endpackage

// ==== src/slot_fetch.sv ====
/*
 * Read-only client slot on the shared SDRAM
 * Keeps the last fetched word and its address. A miss raises a request
 * at the address plus the region offset, a hit answers from the stored word.
 */
`timescale 1ns/10ps

module slot_fetch #(
    parameter int                   AW     = 16,
    parameter mem_pkg::sdram_addr_t OFFSET = '0
) (
    input  logic                 VB,
    input  logic                 arst_n,
    input  logic                 cs,
    input  logic [AW-1:0]        addr,
    output logic                 ok,
    output mem_pkg::sdram_word_t data,
    output mem_pkg::slot_req_t   req,
    input  logic                 grant_done,
    input  mem_pkg::sdram_word_t rdata
);

    mem_pkg::fetch_state_e state;
    logic [AW-1:0]         last_addr;
    mem_pkg::sdram_word_t  word_q;
    logic                  valid;
    logic                  ok_q;
    logic                  hit;
    logic                  miss;

    // Stored word belongs to the address on the bus
    assign hit  = valid && (addr == last_addr);
    assign miss = (state == mem_pkg::READY) && cs && !hit;

    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            state <= mem_pkg::READY;
            valid <= 1'b0;
            ok_q  <= 1'b0;
        end else begin
            case (state)
                mem_pkg::READY: begin
                    ok_q <= cs && hit;
                    if (miss) begin
                        state <= mem_pkg::FETCH;
                        valid <= 1'b0;
                    end
                end
                mem_pkg::FETCH: begin
                    // Word arrives together with the grant
                    ok_q <= grant_done;
                    if (grant_done) begin
                        state <= mem_pkg::READY;
                        valid <= 1'b1;
                    end
                end
                default: state <= mem_pkg::READY;
            endcase
        end
    end

    // Address of the pending fetch and the returned word
    always_ff @(posedge VB) begin
        if (miss) begin
            last_addr <= addr;
        end
        if ((state == mem_pkg::FETCH) && grant_done) begin
            word_q <= rdata;
        end
    end

    // Client may move on while cs stays high
    assign ok   = cs && ok_q && hit;
    assign data = word_q;

    assign req.req  = (state == mem_pkg::FETCH);
    assign req.addr = OFFSET + mem_pkg::sdram_addr_t'(last_addr);

endmodule

// ==== src/slot_arbiter.sv ====
/*
 * Fixed-priority SDRAM arbiter
 * Picks the loader first, then slots 0 to 2, and runs one
 * req/ack/rdy access at a time. Slots wait while downloading.
 */
`timescale 1ns/10ps

module slot_arbiter (
    input  logic                                    VB,
    input  logic                                    arst_n,
    input  logic                                    downloading,
    input  mem_pkg::slot_req_t [mem_pkg::NSLOTS-1:0] slot_reqs,
    output logic [mem_pkg::NSLOTS-1:0]              grant_done,
    output mem_pkg::sdram_word_t                    rdata,
    input  logic                                    wr_req,
    input  mem_pkg::sdram_req_t                     wr_cmd,
    output logic                                    wr_done,
    output logic                                    sdram_req,
    output mem_pkg::sdram_req_t                     sdram_cmd,
    input  logic                                    sdram_ack,
    input  logic                                    data_rdy,
    input  mem_pkg::sdram_word_t                    data_read
);

    localparam int SW = $clog2(mem_pkg::NSLOTS);

    mem_pkg::arb_state_e state;
    mem_pkg::sdram_req_t cmd_q;
    mem_pkg::sdram_req_t slot_cmd;
    logic [SW-1:0]       sel_q;
    logic [SW-1:0]       pick;
    logic                slot_any;

    // Lowest index wins, scan runs downwards so it is assigned last
    always_comb begin
        slot_any = 1'b0;
        pick     = '0;
        for (int i = mem_pkg::NSLOTS - 1; i >= 0; i--) begin
            if (slot_reqs[i].req && !downloading) begin
                slot_any = 1'b1;
                pick     = SW'(i);
            end
        end
    end

    // Slot accesses are plain word reads
    always_comb begin
        slot_cmd.addr   = slot_reqs[pick].addr;
        slot_cmd.rnw    = 1'b1;
        slot_cmd.wrmask = 2'b11;
        slot_cmd.wdata  = '0;
    end

    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            state <= mem_pkg::IDLE;
        end else begin
            case (state)
                mem_pkg::IDLE: begin
                    if (wr_req || slot_any) begin
                        state <= mem_pkg::WAIT_ACK;
                    end
                end
                mem_pkg::WAIT_ACK: begin
                    // Writes finish at the ack
                    if (sdram_ack) begin
                        state <= cmd_q.rnw ? mem_pkg::WAIT_DATA : mem_pkg::IDLE;
                    end
                end
                mem_pkg::WAIT_DATA: begin
                    if (data_rdy) begin
                        state <= mem_pkg::IDLE;
                    end
                end
                default: state <= mem_pkg::IDLE;
            endcase
        end
    end

    // Command and owner are captured on selection
    always_ff @(posedge VB) begin
        if (state == mem_pkg::IDLE) begin
            sel_q <= pick;
            if (wr_req) begin
                cmd_q <= wr_cmd;
            end else begin
                cmd_q <= slot_cmd;
            end
        end
    end

    assign sdram_req = (state == mem_pkg::WAIT_ACK);
    assign sdram_cmd = cmd_q;
    assign wr_done   = (state == mem_pkg::WAIT_ACK) && sdram_ack && !cmd_q.rnw;

    // Read data goes to all slots, only the owner gets the pulse
    always_comb begin
        grant_done = '0;
        if ((state == mem_pkg::WAIT_DATA) && data_rdy) begin
            grant_done[sel_q] = 1'b1;
        end
    end

    assign rdata = data_read;

endmodule

// ==== src/rom_loader.sv ====
/*
 * ROM download to SDRAM writer
 * Each ioctl byte becomes a masked 16-bit word write,
 * held until the arbiter reports it done.
 */
`timescale 1ns/10ps

module rom_loader (
    input  logic                VB,
    input  logic                arst_n,
    input  logic                downloading,
    input  logic [22:0]         ioctl_addr,
    input  logic [7:0]          ioctl_data,
    input  logic                ioctl_wr,
    output logic                prog_we,
    output mem_pkg::sdram_req_t prog_cmd,
    input  logic                wr_done
);

    logic take;

    // Bytes arriving during a pending write are lost
    assign take = downloading && ioctl_wr && !prog_we;

    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
        end else if (take) begin
            prog_we <= 1'b1;
        end else if (wr_done) begin
            prog_we <= 1'b0;
        end
    end

    always_ff @(posedge VB) begin
        if (take) begin
            prog_cmd.addr  <= ioctl_addr[22:1];
            prog_cmd.rnw   <= 1'b0;
            // Odd byte goes high, even byte goes low
            prog_cmd.wrmask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            prog_cmd.wdata <= {ioctl_data, ioctl_data};
        end
    end

endmodule

// ==== src/mem_subsys.sv ====
/*
 * Shared SDRAM memory subsystem
 * Main, graphics and sound ROM slots plus the download writer,
 * all multiplexed onto one SDRAM controller port.
 */
`timescale 1ns/10ps

module mem_subsys #(
    parameter int                   MAIN_AW    = 19,
    parameter int                   GFX_AW     = 20,
    parameter int                   SND_AW     = 16,
    parameter mem_pkg::sdram_addr_t MAIN_OFFSET = 22'h00_0000,
    parameter mem_pkg::sdram_addr_t GFX_OFFSET  = 22'h0A_8000,
    parameter mem_pkg::sdram_addr_t SND_OFFSET  = 22'h08_0000
) (
    input  logic                 VB,
    input  logic                 arst_n,
    input  logic                 downloading,
    // ROM download
    input  logic [22:0]          ioctl_addr,
    input  logic [7:0]           ioctl_data,
    input  logic                 ioctl_wr,
    output logic                 prog_we,
    // Main program ROM
    input  logic                 main_cs,
    input  logic [MAIN_AW-1:0]   main_addr,
    output logic                 main_ok,
    output mem_pkg::sdram_word_t main_data,
    // Graphics ROM
    input  logic                 gfx_cs,
    input  logic [GFX_AW-1:0]    gfx_addr,
    output logic                 gfx_ok,
    output mem_pkg::sdram_word_t gfx_data,
    // Sound ROM
    input  logic                 snd_cs,
    input  logic [SND_AW-1:0]    snd_addr,
    output logic                 snd_ok,
    output mem_pkg::sdram_word_t snd_data,
    // SDRAM controller
    output logic                 sdram_req,
    output mem_pkg::sdram_req_t  sdram_cmd,
    input  logic                 sdram_ack,
    input  logic                 data_rdy,
    input  mem_pkg::sdram_word_t data_read
);

    mem_pkg::slot_req_t [mem_pkg::NSLOTS-1:0] slot_reqs;
    logic [mem_pkg::NSLOTS-1:0]               grant_done;
    mem_pkg::sdram_word_t                     rdata;
    mem_pkg::sdram_req_t                      prog_cmd;
    logic                                     wr_done;

    slot_fetch #(.AW(MAIN_AW), .OFFSET(MAIN_OFFSET)) u_main_slot (
        .VB         ( VB            ),
        .arst_n     ( arst_n        ),
        .cs         ( main_cs       ),
        .addr       ( main_addr     ),
        .ok         ( main_ok       ),
        .data       ( main_data     ),
        .req        ( slot_reqs[0]  ),
        .grant_done ( grant_done[0] ),
        .rdata      ( rdata         )
    );

    slot_fetch #(.AW(GFX_AW), .OFFSET(GFX_OFFSET)) u_gfx_slot (
        .VB         ( VB            ),
        .arst_n     ( arst_n        ),
        .cs         ( gfx_cs        ),
        .addr       ( gfx_addr      ),
        .ok         ( gfx_ok        ),
        .data       ( gfx_data      ),
        .req        ( slot_reqs[1]  ),
        .grant_done ( grant_done[1] ),
        .rdata      ( rdata         )
    );

    slot_fetch #(.AW(SND_AW), .OFFSET(SND_OFFSET)) u_snd_slot (
        .VB         ( VB            ),
        .arst_n     ( arst_n        ),
        .cs         ( snd_cs        ),
        .addr       ( snd_addr      ),
        .ok         ( snd_ok        ),
        .data       ( snd_data      ),
        .req        ( slot_reqs[2]  ),
        .grant_done ( grant_done[2] ),
        .rdata      ( rdata         )
    );

    rom_loader u_loader (
        .VB          ( VB          ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prog_we     ( prog_we     ),
        .prog_cmd    ( prog_cmd    ),
        .wr_done     ( wr_done     )
    );

    slot_arbiter u_arbiter (
        .VB          ( VB          ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .slot_reqs   ( slot_reqs   ),
        .grant_done  ( grant_done  ),
        .rdata       ( rdata       ),
        .wr_req      ( prog_we     ),
        .wr_cmd      ( prog_cmd    ),
        .wr_done     ( wr_done     ),
        .sdram_req   ( sdram_req   ),
        .sdram_cmd   ( sdram_cmd   ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   )
    );

endmodule

// ==== verification/clk_gen.sv ====
/*
 * Testbench clock and reset
 * 4 ns clock, reset held low for four cycles.
 */
`timescale 1ns/10ps

module clk_gen (
    output logic VB,
    output logic arst_n
);

    initial begin
        VB = 1'b0;
        forever #2 VB = ~VB;
    end

    // Released on a falling edge, away from the DUT's active edge
    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge VB);
        @(negedge VB);
        arst_n = 1'b1;
    end

endmodule

// ==== verification/sdram_model.sv ====
/*
 * Behavioral SDRAM controller
 * Answers one request at a time with a random ack delay and, for reads,
 * a random data delay. Unwritten words follow a fixed address pattern.
 */
`timescale 1ns/10ps

module sdram_model (
    input  logic                 VB,
    input  logic                 arst_n,
    input  logic                 sdram_req,
    input  mem_pkg::sdram_req_t  sdram_cmd,
    output logic                 sdram_ack,
    output logic                 data_rdy,
    output mem_pkg::sdram_word_t data_read
);

    mem_pkg::sdram_word_t mem [mem_pkg::sdram_addr_t];
    logic [31:0]          rng_state;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Unwritten words fold the upper address bits into the top of the pattern
    function automatic mem_pkg::sdram_word_t read_word(input mem_pkg::sdram_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a[15:0] ^ 16'hA5C3 ^ {a[21:16], 10'h000};
    endfunction

    // Delay of 1 to 4 cycles
    task automatic next_delay(output int d);
        rng_state = xorshift32(rng_state);
        d = 1 + int'(rng_state[1:0]);
    endtask

    initial begin
        mem_pkg::sdram_req_t  cmd;
        mem_pkg::sdram_word_t word;
        int                   delay;
        rng_state = 32'd51877;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(negedge VB);
            if (arst_n && sdram_req) begin
                cmd = sdram_cmd;
                next_delay(delay);
                repeat (delay - 1) @(negedge VB);
                sdram_ack = 1'b1;
                if (!cmd.rnw) begin
                    word = read_word(cmd.addr);
                    if (!cmd.wrmask[1]) begin
                        word[15:8] = cmd.wdata[15:8];
                    end
                    if (!cmd.wrmask[0]) begin
                        word[7:0] = cmd.wdata[7:0];
                    end
                    mem[cmd.addr] = word;
                end
                @(negedge VB);
                sdram_ack = 1'b0;
                if (cmd.rnw) begin
                    next_delay(delay);
                    repeat (delay - 1) @(negedge VB);
                    data_rdy  = 1'b1;
                    data_read = read_word(cmd.addr);
                    @(negedge VB);
                    data_rdy  = 1'b0;
                end
            end
        end
    end

endmodule

// ==== verification/tb_mem_subsys.sv ====
/*
 * Testbench for the shared SDRAM memory subsystem
 * Applies a table of loader writes and slot reads, checks data, request
 * addresses, hit latency and priority order against a shadow memory.
 */
`timescale 1ns/10ps

module tb_mem_subsys;

    localparam int TIMEOUT = 200;

    localparam logic [1:0] OP_LOAD = 2'd0;
    localparam logic [1:0] OP_READ = 2'd1;
    localparam logic [1:0] OP_HOLD = 2'd2;
    localparam logic [1:0] OP_ALL  = 2'd3;

    typedef struct packed {
        logic [1:0]  op;
        logic [1:0]  slot;
        logic [22:0] addr;
        logic [7:0]  value;
    } row_t;

    logic                 VB;
    logic                 arst_n;
    logic                 downloading;
    logic [22:0]          ioctl_addr;
    logic [7:0]           ioctl_data;
    logic                 ioctl_wr;
    logic                 prog_we;
    logic                 main_cs;
    logic [18:0]          main_addr;
    logic                 main_ok;
    mem_pkg::sdram_word_t main_data;
    logic                 gfx_cs;
    logic [19:0]          gfx_addr;
    logic                 gfx_ok;
    mem_pkg::sdram_word_t gfx_data;
    logic                 snd_cs;
    logic [15:0]          snd_addr;
    logic                 snd_ok;
    mem_pkg::sdram_word_t snd_data;
    logic                 sdram_req;
    mem_pkg::sdram_req_t  sdram_cmd;
    logic                 sdram_ack;
    logic                 data_rdy;
    mem_pkg::sdram_word_t data_read;

    row_t                 rows [$];
    mem_pkg::sdram_req_t  cmd_log [$];
    mem_pkg::sdram_word_t shadow [mem_pkg::sdram_addr_t];
    logic [22:0]          last_addr [3];
    logic                 last_valid [3];
    logic                 req_seen;
    int                   errors;

    clk_gen u_clk_gen (
        .VB     ( VB     ),
        .arst_n ( arst_n )
    );

    mem_subsys u_mem_subsys (
        .VB          ( VB          ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prog_we     ( prog_we     ),
        .main_cs     ( main_cs     ),
        .main_addr   ( main_addr   ),
        .main_ok     ( main_ok     ),
        .main_data   ( main_data   ),
        .gfx_cs      ( gfx_cs      ),
        .gfx_addr    ( gfx_addr    ),
        .gfx_ok      ( gfx_ok      ),
        .gfx_data    ( gfx_data    ),
        .snd_cs      ( snd_cs      ),
        .snd_addr    ( snd_addr    ),
        .snd_ok      ( snd_ok      ),
        .snd_data    ( snd_data    ),
        .sdram_req   ( sdram_req   ),
        .sdram_cmd   ( sdram_cmd   ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   )
    );

    sdram_model u_sdram_model (
        .VB        ( VB        ),
        .arst_n    ( arst_n    ),
        .sdram_req ( sdram_req ),
        .sdram_cmd ( sdram_cmd ),
        .sdram_ack ( sdram_ack ),
        .data_rdy  ( data_rdy  ),
        .data_read ( data_read )
    );

    // Every new SDRAM request, in issue order
    initial req_seen = 1'b0;
    always @(negedge VB) begin
        if (sdram_req && !req_seen) begin
            cmd_log.push_back(sdram_cmd);
        end
        req_seen <= sdram_req;
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic close_run();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        errors++;
        $display("Timeout at %0t while waiting for %s", $time, what);
        close_run();
    endtask

    function automatic mem_pkg::sdram_addr_t slot_offset(input int slot);
        case (slot)
            0: return 22'h00_0000;
            1: return 22'h0A_8000;
            default: return 22'h08_0000;
        endcase
    endfunction

    function automatic string slot_name(input int slot);
        case (slot)
            0: return "main";
            1: return "gfx";
            default: return "snd";
        endcase
    endfunction

    function automatic logic slot_ok(input int slot);
        case (slot)
            0: return main_ok;
            1: return gfx_ok;
            default: return snd_ok;
        endcase
    endfunction

    function automatic mem_pkg::sdram_word_t slot_data(input int slot);
        case (slot)
            0: return main_data;
            1: return gfx_data;
            default: return snd_data;
        endcase
    endfunction

    // Model rule for words the loader never touched
    function automatic mem_pkg::sdram_word_t expected_word(input mem_pkg::sdram_addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a[15:0] ^ 16'hA5C3 ^ {a[21:16], 10'h000};
    endfunction

    task automatic drive_slot(input int slot, input logic cs, input logic [22:0] a);
        case (slot)
            0: begin
                main_cs   = cs;
                main_addr = a[18:0];
            end
            1: begin
                gfx_cs   = cs;
                gfx_addr = a[19:0];
            end
            default: begin
                snd_cs   = cs;
                snd_addr = a[15:0];
            end
        endcase
    endtask

    function automatic row_t make_row(input logic [1:0] op, input logic [1:0] slot,
                                      input logic [22:0] addr, input logic [7:0] value);
        row_t r;
        r.op    = op;
        r.slot  = slot;
        r.addr  = addr;
        r.value = value;
        return r;
    endfunction

    // Loads use byte addresses inside the graphics region, reads use word addresses
    task automatic build_table();
        rows.push_back(make_row(OP_LOAD, 2'd1, 23'h00020, 8'h3C));
        rows.push_back(make_row(OP_LOAD, 2'd1, 23'h00021, 8'h7E));
        rows.push_back(make_row(OP_LOAD, 2'd1, 23'h00043, 8'h99));
        rows.push_back(make_row(OP_READ, 2'd1, 23'h00010, 8'h00));
        rows.push_back(make_row(OP_READ, 2'd1, 23'h00010, 8'h00));
        rows.push_back(make_row(OP_READ, 2'd1, 23'h00021, 8'h00));
        rows.push_back(make_row(OP_READ, 2'd0, 23'h12345, 8'h00));
        rows.push_back(make_row(OP_READ, 2'd0, 23'h12345, 8'h00));
        rows.push_back(make_row(OP_READ, 2'd2, 23'h0BEEF, 8'h00));
        rows.push_back(make_row(OP_READ, 2'd2, 23'h0BEF0, 8'h00));
        rows.push_back(make_row(OP_ALL,  2'd0, 23'h00777, 8'h00));
        rows.push_back(make_row(OP_HOLD, 2'd0, 23'h00100, 8'h00));
        rows.push_back(make_row(OP_READ, 2'd1, 23'h45678, 8'h00));
        rows.push_back(make_row(OP_ALL,  2'd0, 23'h01234, 8'h00));
        rows.push_back(make_row(OP_HOLD, 2'd2, 23'h00ABC, 8'h00));
        rows.push_back(make_row(OP_LOAD, 2'd1, 23'h00101, 8'h5A));
        rows.push_back(make_row(OP_READ, 2'd1, 23'h00080, 8'h00));
    endtask

    task automatic run_load(input int slot, input logic [22:0] byte_addr, input logic [7:0] value);
        logic [22:0]          ioctl_a;
        mem_pkg::sdram_addr_t word_addr;
        mem_pkg::sdram_word_t w;
        mem_pkg::byte_mask_t  exp_mask;
        int                   n_before;
        int                   cycles;
        ioctl_a   = {slot_offset(slot), 1'b0} + byte_addr;
        word_addr = ioctl_a[22:1];
        n_before  = cmd_log.size();
        downloading = 1'b1;
        ioctl_addr  = ioctl_a;
        ioctl_data  = value;
        ioctl_wr    = 1'b1;
        @(negedge VB);
        ioctl_wr = 1'b0;
        check("prog_we", prog_we, 1);
        cycles = 0;
        while (prog_we) begin
            @(negedge VB);
            cycles++;
            if (cycles > TIMEOUT) begin
                timeout_abort("prog_we to fall after a loader write");
            end
        end
        // Active low mask, only the lane of the addressed byte is enabled
        exp_mask = 2'b11;
        exp_mask[ioctl_a[0]] = 1'b0;
        check("sdram_req count", cmd_log.size(), n_before + 1);
        check("sdram_cmd.rnw", cmd_log[n_before].rnw, 0);
        check("sdram_cmd.addr", cmd_log[n_before].addr, word_addr);
        check("sdram_cmd.wrmask", cmd_log[n_before].wrmask, exp_mask);
        check("sdram_cmd.wdata", cmd_log[n_before].wdata, {value, value});
        w = expected_word(word_addr);
        if (ioctl_a[0]) begin
            w[15:8] = value;
        end else begin
            w[7:0] = value;
        end
        shadow[word_addr] = w;
    endtask

    // Hold keeps downloading high for a while to show that the read waits
    task automatic run_read(input int slot, input logic [22:0] a, input logic hold);
        mem_pkg::sdram_addr_t abs_addr;
        logic                 expect_hit;
        int                   n_before;
        int                   cycles;
        string                name;
        name       = slot_name(slot);
        abs_addr   = slot_offset(slot) + mem_pkg::sdram_addr_t'(a);
        expect_hit = last_valid[slot] && (last_addr[slot] == a);
        n_before   = cmd_log.size();
        downloading = hold;
        drive_slot(slot, 1'b1, a);
        if (hold) begin
            repeat (12) @(negedge VB);
            check("sdram_req count while downloading", cmd_log.size(), n_before);
            check({name, "_ok"}, slot_ok(slot), 0);
            downloading = 1'b0;
        end
        cycles = 0;
        do begin
            @(negedge VB);
            cycles++;
            if (cycles > TIMEOUT) begin
                timeout_abort({name, "_ok after a read"});
            end
        end while (!slot_ok(slot));
        check({name, "_data"}, slot_data(slot), expected_word(abs_addr));
        if (expect_hit) begin
            check({name, "_ok latency"}, cycles, 1);
            check("sdram_req count", cmd_log.size(), n_before);
        end else begin
            check("sdram_req count", cmd_log.size(), n_before + 1);
            check("sdram_cmd.rnw", cmd_log[n_before].rnw, 1);
            check("sdram_cmd.addr", cmd_log[n_before].addr, abs_addr);
        end
        drive_slot(slot, 1'b0, a);
        @(negedge VB);
        last_valid[slot] = 1'b1;
        last_addr[slot]  = a;
    endtask

    // All three slots miss together and are served in priority order
    task automatic run_all(input logic [22:0] a);
        int n_before;
        int cycles;
        n_before = cmd_log.size();
        downloading = 1'b0;
        for (int s = 0; s < 3; s++) begin
            drive_slot(s, 1'b1, a);
        end
        cycles = 0;
        do begin
            @(negedge VB);
            cycles++;
            if (cycles > TIMEOUT) begin
                timeout_abort("ok of all three slots");
            end
        end while (!(main_ok && gfx_ok && snd_ok));
        check("sdram_req count", cmd_log.size(), n_before + 3);
        for (int s = 0; s < 3; s++) begin
            check({slot_name(s), "_data"}, slot_data(s),
                  expected_word(slot_offset(s) + mem_pkg::sdram_addr_t'(a)));
            check("sdram_cmd.addr", cmd_log[n_before + s].addr,
                  slot_offset(s) + mem_pkg::sdram_addr_t'(a));
        end
        for (int s = 0; s < 3; s++) begin
            drive_slot(s, 1'b0, a);
            last_valid[s] = 1'b1;
            last_addr[s]  = a;
        end
        @(negedge VB);
    endtask

    initial begin
        int   cycles;
        row_t r;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        main_cs     = 1'b0;
        main_addr   = '0;
        gfx_cs      = 1'b0;
        gfx_addr    = '0;
        snd_cs      = 1'b0;
        snd_addr    = '0;
        errors      = 0;
        for (int s = 0; s < 3; s++) begin
            last_valid[s] = 1'b0;
            last_addr[s]  = '0;
        end
        build_table();

        cycles = 0;
        while (arst_n !== 1'b1) begin
            @(negedge VB);
            cycles++;
            if (cycles > TIMEOUT) begin
                timeout_abort("reset release");
            end
        end
        @(negedge VB);
        check("sdram_req", sdram_req, 0);
        check("prog_we", prog_we, 0);
        check("main_ok", main_ok, 0);
        check("gfx_ok", gfx_ok, 0);
        check("snd_ok", snd_ok, 0);

        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            case (r.op)
                OP_LOAD: run_load(int'(r.slot), r.addr, r.value);
                OP_READ: run_read(int'(r.slot), r.addr, 1'b0);
                OP_HOLD: run_read(int'(r.slot), r.addr, 1'b1);
                default: run_all(r.addr);
            endcase
        end
        close_run();
    end

endmodule

// ==== project.f ====
src/mem_pkg.sv
src/slot_fetch.sv
src/slot_arbiter.sv
src/rom_loader.sv
src/mem_subsys.sv
verification/clk_gen.sv
verification/sdram_model.sv
verification/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_mem_subsys -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Test failures found" sim.log; then
    exit 1
fi
exit 0
